// ==== hdl/screen_pkg.sv ====
// Screen geometry, pixel and colour types, frame buffer credit constants
`default_nettype none

package screen_pkg;

	// ============================================================
	// Geometry
	// ============================================================
	localparam int SCREEN_W = 160;
	localparam int SCREEN_H = 120;

	typedef logic [7:0] x_t;  // Pixel column
	typedef logic [6:0] y_t;  // Pixel row

	// ============================================================
	// Colours, 3 bit RGB
	// ============================================================
	typedef logic [2:0] colour_t;

	localparam colour_t COLOUR_BLACK = 3'd0;  // Clear and erase
	localparam colour_t COLOUR_BIRD  = 3'd4;  // Red
	localparam colour_t COLOUR_PIPE  = 3'd2;  // Green

	// Frame buffer flow control
	typedef logic [2:0] credit_t;
	localparam credit_t FB_CREDITS = 3'd4;

endpackage

`default_nettype wire

// ==== hdl/game_pkg.sv ====
// Bird physics, pipe layout and velocity constants and types
`default_nettype none

package game_pkg;

	import screen_pkg::*;

	// ============================================================
	// Bird
	// ============================================================
	localparam x_t BIRD_X       = 8'd78;
	localparam int BIRD_SIZE    = 4;       // Square edge
	localparam y_t BIRD_START_Y = 7'd58;
	localparam y_t GROUND_Y     = 7'd116;  // Lowest bird row

	// Positive velocity moves up
	typedef logic signed [3:0] velocity_t;

	localparam velocity_t JUMP_V   = 4'sd2;
	localparam velocity_t GRAVITY  = 4'sd1;
	localparam velocity_t MAX_FALL = -4'sd4;

	// ============================================================
	// Pipes
	// ============================================================
	localparam int PIPE_COUNT = 3;
	localparam x_t PIPE_W     = 8'd6;
	localparam y_t GAP_H      = 7'd40;

	typedef x_t [PIPE_COUNT - 1:0] pipe_x_t;
	typedef y_t [PIPE_COUNT - 1:0] pipe_y_t;

	// Index 0 is the rightmost entry
	localparam pipe_x_t PIPE_START_X = {8'd60, 8'd20, 8'd135};
	localparam pipe_y_t PIPE_GAP_Y   = {7'd30, 7'd60, 7'd40};  // Gap top rows
	localparam x_t      PIPE_WRAP_X  = 8'd154;

endpackage

`default_nettype wire

// ==== hdl/game_control.sv ====
// Frame tick counter, flap edge detect and game sequencing FSM
`default_nettype none

module game_control #(
	parameter int FRAME_TICKS = 833333
) (
	input  logic clk,
	input  logic reset_n,
	input  logic flap,
	input  logic crashed,
	input  logic clear_done,
	input  logic draw_done,
	output logic clear_go,
	output logic draw_go,
	output logic draw_erase,
	output logic step,
	output logic flap_pulse
);

	enum logic [2:0] {CLEAR, FIRST_DRAW, START_WAIT, WAIT_TICK, ERASE, STEP, DRAW}
		state, next_state;

	logic [$clog2(FRAME_TICKS + 1) - 1:0] tick_cnt;
	logic tick;
	logic tick_pending;
	logic flap_q;
	logic flap_edge;
	logic running;
	logic pass_state;
	logic go_sent;  // Start pulse of the current pass already issued

	assign tick = (tick_cnt == FRAME_TICKS - 1);
	assign flap_edge = flap && !flap_q;
	assign running = (state == WAIT_TICK) || (state == ERASE) || (state == STEP)
		|| (state == DRAW);
	assign pass_state = (state == CLEAR) || (state == FIRST_DRAW) || (state == ERASE)
		|| (state == DRAW);

	assign clear_go = (state == CLEAR) && !go_sent;
	assign draw_go = pass_state && (state != CLEAR) && !go_sent;
	assign draw_erase = (state == ERASE);
	assign step = (state == STEP);
	assign flap_pulse = flap_edge && running && !crashed;  // Start flap not forwarded

	always_comb
	begin
		next_state = state;
		case (state)
			CLEAR:      if (clear_done) next_state = FIRST_DRAW;
			FIRST_DRAW: if (draw_done) next_state = START_WAIT;
			START_WAIT: if (flap_edge) next_state = WAIT_TICK;
			WAIT_TICK:  if (tick_pending) next_state = ERASE;
			ERASE:      if (draw_done) next_state = STEP;
			STEP:       next_state = DRAW;
			DRAW:       if (draw_done) next_state = WAIT_TICK;
			default:    next_state = CLEAR;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= CLEAR;
			go_sent <= 1'b0;
			tick_cnt <= '0;
			tick_pending <= 1'b0;
			flap_q <= 1'b0;
		end
		else
		begin
			state <= next_state;
			go_sent <= (next_state == state) && (go_sent || pass_state);
			tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
			// Ticks before the first flap are dropped
			tick_pending <= running && (tick || (tick_pending && state != WAIT_TICK));
			flap_q <= flap;
		end
	end

	// Sprite drawer only finishes passes that were started
	assert property (@(posedge clk) disable iff (!reset_n)
		draw_done |-> (state == FIRST_DRAW || state == ERASE || state == DRAW))
		else $error("draw_done outside a sprite pass");

endmodule

`default_nettype wire

// ==== hdl/bird_physics.sv ====
// Bird height and velocity under gravity and jumps
`default_nettype none

module bird_physics (
	input  logic           clk,
	input  logic           reset_n,
	input  logic           step,
	input  logic           flap_pulse,
	output screen_pkg::y_t bird_y
);

	import screen_pkg::*;
	import game_pkg::*;

	velocity_t        velocity;
	velocity_t        vel_dec;
	velocity_t        vel_fall;
	logic             jump_pending;
	logic signed [8:0] y_fall;  // Wide enough to see both clamps
	y_t               y_free;
	y_t               y_jump;

	always_comb
	begin
		y_fall = $signed({2'b00, bird_y}) - 9'(velocity);
		if (y_fall < 0)
			y_free = '0;
		else if (y_fall > $signed({2'b00, GROUND_Y}))
			y_free = GROUND_Y;
		else
			y_free = y_t'(y_fall);
		vel_dec = velocity - GRAVITY;
		vel_fall = (vel_dec < MAX_FALL) ? MAX_FALL : vel_dec;
		y_jump = (bird_y < y_t'(JUMP_V)) ? '0 : bird_y - y_t'(JUMP_V);  // Stop at the top
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			bird_y <= BIRD_START_Y;
			velocity <= '0;  // Starts at rest
			jump_pending <= 1'b0;
		end
		else
		begin
			jump_pending <= flap_pulse || (jump_pending && !step);
			if (step && jump_pending)
			begin
				velocity <= JUMP_V;
				bird_y <= y_jump;
			end
			else if (step)
			begin
				velocity <= vel_fall;
				bird_y <= y_free;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/obstacle_course.sv ====
// Pipe scrolling and wrap, score counter, sticky pipe and ground collision
`default_nettype none

module obstacle_course (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              step,
	input  screen_pkg::y_t    bird_y,
	output game_pkg::pipe_x_t pipe_x,
	output logic [7:0]        score,
	output logic              crashed
);

	import game_pkg::*;

	logic       hit;
	logic [7:0] pass_cnt;  // Pipes leaving the bird column on this step

	always_comb
	begin : hit_check
		logic [8:0] lo;
		logic [8:0] hi;
		hit = (bird_y >= GROUND_Y);
		pass_cnt = '0;
		for (int i = 0; i < PIPE_COUNT; i++)
		begin
			lo = (pipe_x[i] < 8'd4) ? 9'd0 : 9'(pipe_x[i]) - 9'd4;
			hi = 9'(pipe_x[i]) + 9'(PIPE_W);
			// Inside the pipe span and above or below the gap
			if (9'(BIRD_X) >= lo && 9'(BIRD_X) <= hi
				&& (bird_y <= PIPE_GAP_Y[i] + 7'd1
				|| bird_y >= PIPE_GAP_Y[i] + GAP_H - 7'd4))
				hit = 1'b1;
			if (hi == 9'(BIRD_X))
				pass_cnt = pass_cnt + 8'd1;
		end
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			pipe_x <= PIPE_START_X;
			score <= '0;
			crashed <= 1'b0;
		end
		else
		begin
			crashed <= crashed || hit;
			if (step && !crashed)  // Frozen after a crash
			begin
				score <= score + pass_cnt;
				for (int i = 0; i < PIPE_COUNT; i++)
					pipe_x[i] <= (pipe_x[i] == '0) ? PIPE_WRAP_X : pipe_x[i] - 8'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sprite_draw.sv ====
// Bird and pipe column rasterizer in draw or erase colour
`default_nettype none

module sprite_draw (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                draw_go,
	input  logic                draw_erase,
	input  logic                sprite_gnt,
	input  screen_pkg::y_t      bird_y,
	input  game_pkg::pipe_x_t   pipe_x,
	output logic                sprite_req,
	output screen_pkg::x_t      sprite_x,
	output screen_pkg::y_t      sprite_y,
	output screen_pkg::colour_t sprite_colour,
	output logic                draw_done
);

	import screen_pkg::*;
	import game_pkg::*;

	enum logic [1:0] {S_IDLE, S_BIRD, S_UPPER, S_LOWER} phase;

	logic [1:0] idx;       // Current pipe
	logic       start;
	logic       last_pipe;
	logic       col_last;
	logic       row_last;
	logic [8:0] pipe_end;  // Right edge before clipping
	x_t         px;
	y_t         gap;
	x_t         first_x;
	x_t         last_x;
	x_t         next_x;
	y_t         last_y;
	y_t         next_y;

	// Snapshot of the scene for this pass
	y_t         bird_y_q;
	pipe_x_t    pipe_x_q;
	logic       erase_q;

	assign start = draw_go && (phase == S_IDLE);
	assign last_pipe = (idx == 2'(PIPE_COUNT - 1));
	assign px = pipe_x_q[idx];
	assign gap = PIPE_GAP_Y[idx];
	assign pipe_end = 9'(px) + 9'(PIPE_W) - 9'd1;
	assign col_last = (sprite_x == last_x);
	assign row_last = (sprite_y == last_y);

	assign sprite_req = (phase != S_IDLE);
	assign sprite_colour = erase_q ? COLOUR_BLACK
		: ((phase == S_BIRD) ? COLOUR_BIRD : COLOUR_PIPE);

	// Bounds of the current section and start of the next one
	always_comb
	begin
		first_x = px;
		last_x = (pipe_end > 9'(SCREEN_W - 1)) ? x_t'(SCREEN_W - 1) : pipe_end[7:0];
		last_y = gap;
		next_x = px;
		next_y = y_t'(gap + GAP_H);
		case (phase)
			S_BIRD:
			begin
				first_x = BIRD_X;
				last_x = x_t'(BIRD_X + BIRD_SIZE - 1);
				last_y = y_t'(bird_y_q + BIRD_SIZE - 1);
				next_x = pipe_x_q[0];
				next_y = '0;
			end
			S_LOWER:
			begin
				last_y = y_t'(SCREEN_H - 1);
				next_x = last_pipe ? px : pipe_x_q[idx + 2'd1];
				next_y = '0;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			phase <= S_IDLE;
			idx <= '0;
			draw_done <= 1'b0;
		end
		else
		begin
			draw_done <= 1'b0;
			if (start)
			begin
				phase <= S_BIRD;
				idx <= '0;
			end
			else if (sprite_gnt && col_last && row_last)
			begin
				case (phase)
					S_BIRD:  phase <= S_UPPER;
					S_UPPER: phase <= S_LOWER;
					S_LOWER:
					begin
						phase <= last_pipe ? S_IDLE : S_UPPER;
						idx <= last_pipe ? idx : idx + 2'd1;
						draw_done <= last_pipe;
					end
					default: phase <= S_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			bird_y_q <= bird_y;
			pipe_x_q <= pipe_x;
			erase_q <= draw_erase;
			sprite_x <= BIRD_X;
			sprite_y <= bird_y;
		end
		else if (sprite_gnt)
		begin
			if (!col_last)
				sprite_x <= sprite_x + 8'd1;
			else if (!row_last)
			begin
				sprite_x <= first_x;  // Next row
				sprite_y <= sprite_y + 7'd1;
			end
			else
			begin
				sprite_x <= next_x;
				sprite_y <= next_y;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/screen_clear.sv ====
// Full screen raster walk in black
`default_nettype none

module screen_clear (
	input  logic           clk,
	input  logic           reset_n,
	input  logic           clear_go,
	input  logic           clear_gnt,
	output logic           clear_req,
	output screen_pkg::x_t clear_x,
	output screen_pkg::y_t clear_y,
	output logic           clear_done
);

	import screen_pkg::*;

	logic row_end;

	assign row_end = (clear_x == x_t'(SCREEN_W - 1));

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			clear_req <= 1'b0;
			clear_x <= '0;
			clear_y <= '0;
			clear_done <= 1'b0;
		end
		else
		begin
			clear_done <= 1'b0;
			if (clear_go && !clear_req)
			begin
				clear_req <= 1'b1;
				clear_x <= '0;
				clear_y <= '0;
			end
			else if (clear_gnt)
			begin
				clear_x <= row_end ? '0 : clear_x + 8'd1;
				if (row_end && clear_y == y_t'(SCREEN_H - 1))
				begin
					clear_req <= 1'b0;  // Bottom right pixel granted
					clear_done <= 1'b1;
				end
				else if (row_end)
					clear_y <= clear_y + 7'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/pixel_arbiter.sv ====
// Fixed priority pixel arbiter with frame buffer credit counter
`default_nettype none

module pixel_arbiter (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                clear_req,
	input  screen_pkg::x_t      clear_x,
	input  screen_pkg::y_t      clear_y,
	input  logic                sprite_req,
	input  screen_pkg::x_t      sprite_x,
	input  screen_pkg::y_t      sprite_y,
	input  screen_pkg::colour_t sprite_colour,
	input  logic                credit_return,
	output logic                clear_gnt,
	output logic                sprite_gnt,
	output logic                pix_valid,
	output screen_pkg::x_t      pix_x,
	output screen_pkg::y_t      pix_y,
	output screen_pkg::colour_t pix_colour
);

	import screen_pkg::*;

	credit_t credits;
	logic    can_grant;

	// The pixel on the port this cycle still holds a credit
	assign can_grant = (credits > credit_t'(pix_valid));
	assign clear_gnt = clear_req && can_grant;
	assign sprite_gnt = sprite_req && !clear_req && can_grant;

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			credits <= FB_CREDITS;
			pix_valid <= 1'b0;
		end
		else
		begin
			pix_valid <= clear_gnt || sprite_gnt;
			case ({pix_valid, credit_return})
				2'b10:   credits <= credits - 3'd1;
				2'b01:   credits <= credits + 3'd1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		pix_x <= clear_gnt ? clear_x : sprite_x;
		pix_y <= clear_gnt ? clear_y : sprite_y;
		pix_colour <= clear_gnt ? COLOUR_BLACK : sprite_colour;
	end

	assert property (@(posedge clk) disable iff (!reset_n) credits <= FB_CREDITS)
		else $error("more credits returned than granted");
	assert property (@(posedge clk) disable iff (!reset_n) pix_valid |-> credits != '0)
		else $error("pixel sent without a credit");
	// A waiting clear pixel is held until granted
	assert property (@(posedge clk) disable iff (!reset_n)
		clear_req && !clear_gnt |=> clear_req && $stable(clear_x) && $stable(clear_y))
		else $error("clear pixel dropped while waiting");

endmodule

`default_nettype wire

// ==== hdl/flap_game_top.sv ====
// Game core top level, control, physics, obstacles, drawers and pixel arbiter
`default_nettype none

module flap_game_top #(
	parameter int FRAME_TICKS = 833333  // Clocks per game step
) (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                flap,
	input  logic                credit_return,
	output logic                pix_valid,
	output screen_pkg::x_t      pix_x,
	output screen_pkg::y_t      pix_y,
	output screen_pkg::colour_t pix_colour,
	output logic [7:0]          score,
	output logic                crashed
);

	import screen_pkg::*;
	import game_pkg::*;

	logic clear_go;
	logic clear_done;
	logic draw_go;
	logic draw_erase;
	logic draw_done;
	logic step;
	logic flap_pulse;

	y_t      bird_y;
	pipe_x_t pipe_x;

	// Drawer to arbiter
	logic    clear_req;
	logic    clear_gnt;
	x_t      clear_x;
	y_t      clear_y;
	logic    sprite_req;
	logic    sprite_gnt;
	x_t      sprite_x;
	y_t      sprite_y;
	colour_t sprite_colour;

	game_control #(.FRAME_TICKS(FRAME_TICKS)) i_game_control (
		.clk(clk), .reset_n(reset_n), .flap(flap), .crashed(crashed),
		.clear_done(clear_done), .draw_done(draw_done), .clear_go(clear_go),
		.draw_go(draw_go), .draw_erase(draw_erase), .step(step), .flap_pulse(flap_pulse)
	);

	bird_physics i_bird_physics (
		.clk(clk), .reset_n(reset_n), .step(step), .flap_pulse(flap_pulse), .bird_y(bird_y)
	);

	obstacle_course i_obstacle_course (
		.clk(clk), .reset_n(reset_n), .step(step), .bird_y(bird_y),
		.pipe_x(pipe_x), .score(score), .crashed(crashed)
	);

	sprite_draw i_sprite_draw (
		.clk(clk), .reset_n(reset_n), .draw_go(draw_go), .draw_erase(draw_erase),
		.sprite_gnt(sprite_gnt), .bird_y(bird_y), .pipe_x(pipe_x),
		.sprite_req(sprite_req), .sprite_x(sprite_x), .sprite_y(sprite_y),
		.sprite_colour(sprite_colour), .draw_done(draw_done)
	);

	screen_clear i_screen_clear (
		.clk(clk), .reset_n(reset_n), .clear_go(clear_go), .clear_gnt(clear_gnt),
		.clear_req(clear_req), .clear_x(clear_x), .clear_y(clear_y), .clear_done(clear_done)
	);

	pixel_arbiter i_pixel_arbiter (
		.clk(clk), .reset_n(reset_n), .clear_req(clear_req), .clear_x(clear_x),
		.clear_y(clear_y), .sprite_req(sprite_req), .sprite_x(sprite_x), .sprite_y(sprite_y),
		.sprite_colour(sprite_colour), .credit_return(credit_return), .clear_gnt(clear_gnt),
		.sprite_gnt(sprite_gnt), .pix_valid(pix_valid), .pix_x(pix_x), .pix_y(pix_y),
		.pix_colour(pix_colour)
	);

endmodule

`default_nettype wire

// ==== bench/flap_tb.sv ====
// Testbench with clock, reset, credit return, pixel monitor, reference model and directed tests
`default_nettype none

module flap_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import screen_pkg::*;
	import game_pkg::*;

	localparam int FRAME_TICKS   = 4000;
	localparam int PIXEL_TIMEOUT = 20000;  // More than one frame
	localparam int CLEAR_PIXELS  = SCREEN_W * SCREEN_H;

	logic       clk;
	logic       reset_n;
	logic       flap;
	logic       credit_return = 1'b0;
	logic       pix_valid;
	x_t         pix_x;
	y_t         pix_y;
	colour_t    pix_colour;
	logic [7:0] score;
	logic       crashed;

	logic [17:0] pix_q[$];       // {x, y, colour} in port order
	int          pix_count = 0;
	logic        hold_credits = 1'b0;
	logic        valid_d1 = 1'b0;
	int          owed = 0;        // Credits waiting to go back
	integer      seed;

	// Reference model state
	int m_bird_y;
	int m_vel;
	int m_jump;
	int m_px[PIPE_COUNT];
	int m_score;
	int m_crashed;

	flap_game_top #(.FRAME_TICKS(FRAME_TICKS)) i_flap_game_top (
		.clk(clk), .reset_n(reset_n), .flap(flap), .credit_return(credit_return),
		.pix_valid(pix_valid), .pix_x(pix_x), .pix_y(pix_y), .pix_colour(pix_colour),
		.score(score), .crashed(crashed)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ============================================================
	// Frame buffer side
	// ============================================================
	always @(posedge clk)
	begin
		if (!reset_n)
		begin
			valid_d1 <= 1'b0;
			owed = 0;
			credit_return <= 1'b0;
		end
		else
		begin
			valid_d1 <= pix_valid;
			if (valid_d1)
				owed = owed + 1;
			if (!hold_credits && owed > 0)
			begin
				credit_return <= 1'b1;  // Two cycles after the write
				owed = owed - 1;
			end
			else
				credit_return <= 1'b0;
		end
	end

	always @(negedge clk)
	begin
		if (reset_n && pix_valid)
		begin
			pix_q.push_back({pix_x, pix_y, pix_colour});
			pix_count = pix_count + 1;
		end
	end

	// ============================================================
	// Checking helpers
	// ============================================================
	task automatic stop_run();
	begin
		$display("FAIL: see errors above");
		$fatal(1, "stopping at first error");
	end
	endtask

	task automatic compare(input string name, input logic [31:0] got, input int expected);
	begin
		if (got !== expected)
		begin
			$display("ERROR: time %0t %s got %0d expected %0d", $time, name, got, expected);
			stop_run();
		end
	end
	endtask

	task automatic give_up(input string what);
	begin
		$display("TIMEOUT: %s", what);
		stop_run();
	end
	endtask

	task automatic pop_pixel(output x_t x, output y_t y, output colour_t c);
		int waited;
	begin
		waited = 0;
		while (pix_q.size() == 0)
		begin
			@(posedge clk);
			waited++;
			if (waited > PIXEL_TIMEOUT)
				give_up("no pixel write arrived from the game core");
		end
		{x, y, c} = pix_q.pop_front();
	end
	endtask

	task automatic expect_pixel(input int x, input int y, input int c);
		x_t      gx;
		y_t      gy;
		colour_t gc;
	begin
		pop_pixel(gx, gy, gc);
		compare("pix_x", 32'(gx), x);
		compare("pix_y", 32'(gy), y);
		compare("pix_colour", 32'(gc), c);
	end
	endtask

	task automatic expect_idle();
	begin
		compare("pix_valid", pix_valid, 0);
		compare("score", score, 0);
		compare("crashed", crashed, 0);
	end
	endtask

	task automatic expect_quiet(input int cycles);
		int base;
	begin
		@(posedge clk);
		base = pix_count;
		repeat (cycles) @(posedge clk);
		compare("pixels_while_waiting", pix_count - base, 0);
	end
	endtask

	// ============================================================
	// Reference model of bird, pipes, score and crash
	// ============================================================
	task automatic init_model();
	begin
		m_bird_y = BIRD_START_Y;
		m_vel = 0;
		m_jump = 0;
		for (int i = 0; i < PIPE_COUNT; i++)
			m_px[i] = PIPE_START_X[i];
		m_score = 0;
		m_crashed = 0;
	end
	endtask

	function automatic int bird_hits();
		int lo;
		int gap;
	begin
		bird_hits = (m_bird_y >= int'(GROUND_Y));
		for (int i = 0; i < PIPE_COUNT; i++)
		begin
			gap = PIPE_GAP_Y[i];
			lo = (m_px[i] < 4) ? 0 : m_px[i] - 4;
			if (int'(BIRD_X) >= lo && int'(BIRD_X) <= m_px[i] + int'(PIPE_W)
				&& (m_bird_y <= gap + 1 || m_bird_y >= gap + int'(GAP_H) - 4))
				bird_hits = 1;
		end
	end
	endfunction

	task automatic advance_model();
		int ny;
	begin
		if (!m_crashed)
		begin
			for (int i = 0; i < PIPE_COUNT; i++)
			begin
				if (m_px[i] + int'(PIPE_W) == int'(BIRD_X))
					m_score++;  // Pipe clears the bird
				m_px[i] = (m_px[i] == 0) ? int'(PIPE_WRAP_X) : m_px[i] - 1;
			end
		end
		if (m_jump)
		begin
			m_vel = int'(JUMP_V);
			m_bird_y = (m_bird_y < int'(JUMP_V)) ? 0 : m_bird_y - int'(JUMP_V);
			m_jump = 0;
		end
		else
		begin
			ny = m_bird_y - m_vel;  // Positive velocity moves up
			m_bird_y = (ny < 0) ? 0 : ((ny > int'(GROUND_Y)) ? int'(GROUND_Y) : ny);
			m_vel = m_vel - int'(GRAVITY);
			if (m_vel < int'(MAX_FALL))
				m_vel = int'(MAX_FALL);
		end
		m_crashed = m_crashed | bird_hits();
	end
	endtask

	// ============================================================
	// Stimulus and test tasks
	// ============================================================
	task automatic apply_reset();
	begin
		@(posedge clk);
		reset_n <= 1'b0;
		repeat (4)
		begin
			@(negedge clk);
			expect_idle();
		end
		@(posedge clk);
		reset_n <= 1'b1;
		@(negedge clk);
		expect_idle();
		pix_q.delete();
		init_model();
	end
	endtask

	task automatic press_flap(input bit forwarded);
	begin
		@(posedge clk);
		flap <= 1'b1;
		repeat (3) @(posedge clk);
		flap <= 1'b0;
		@(posedge clk);
		if (forwarded && !m_crashed)
			m_jump = 1;  // Applied at the next step
	end
	endtask

	task automatic withhold_credits();
		int base;
	begin
		@(posedge clk);
		hold_credits <= 1'b1;
		@(posedge clk);
		base = pix_count;
		repeat (20) @(posedge clk);
		compare("pixels_within_credits", (pix_count - base) <= FB_CREDITS, 1);
		base = pix_count;
		repeat (200) @(posedge clk);
		compare("pixels_without_credits", pix_count - base, 0);
		hold_credits <= 1'b0;
	end
	endtask

	task automatic clear_raster(input bit with_stall);
	begin
		for (int i = 0; i < CLEAR_PIXELS; i++)
		begin
			if (with_stall && i == 1000)
				withhold_credits();
			expect_pixel(i % SCREEN_W, i / SCREEN_W, COLOUR_BLACK);
		end
	end
	endtask

	// Bird square first, then each pipe's upper and lower column
	task automatic sprite_pass(input bit erase);
		int      last;
		int      gap;
		colour_t c;
	begin
		c = erase ? COLOUR_BLACK : COLOUR_BIRD;
		for (int r = m_bird_y; r < m_bird_y + BIRD_SIZE; r++)
			for (int col = int'(BIRD_X); col < int'(BIRD_X) + BIRD_SIZE; col++)
				expect_pixel(col, r, c);
		c = erase ? COLOUR_BLACK : COLOUR_PIPE;
		for (int i = 0; i < PIPE_COUNT; i++)
		begin
			gap = PIPE_GAP_Y[i];
			last = m_px[i] + int'(PIPE_W) - 1;
			if (last > SCREEN_W - 1)
				last = SCREEN_W - 1;  // Clipped at the right edge
			for (int r = 0; r < SCREEN_H; r++)
				if (r <= gap || r >= gap + int'(GAP_H))
					for (int col = m_px[i]; col <= last; col++)
						expect_pixel(col, r, c);
		end
	end
	endtask

	task automatic play_frame();
	begin
		sprite_pass(1'b1);
		advance_model();
		sprite_pass(1'b0);
		@(negedge clk);
		compare("score", score, m_score);
		compare("crashed", crashed, m_crashed);
	end
	endtask

	task automatic free_fall();
	begin
		press_flap(1'b0);  // Start flap only
		for (int f = 0; f < 20; f++)
			play_frame();
		compare("crashed", crashed, 1);
	end
	endtask

	task automatic random_flaps();
	begin
		apply_reset();
		clear_raster(1'b0);
		sprite_pass(1'b0);
		expect_quiet(100);
		press_flap(1'b0);
		for (int f = 0; f < 40; f++)
		begin
			play_frame();
			if ($random(seed) & 1)
				press_flap(1'b1);
		end
		compare("score", score, m_score);
		compare("crashed", crashed, m_crashed);
	end
	endtask

	initial
	begin
		seed = 50;
		reset_n = 1'b0;
		flap = 1'b0;
		apply_reset();
		clear_raster(1'b1);
		sprite_pass(1'b0);  // First draw
		expect_quiet(2000);
		free_fall();
		random_flaps();
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/screen_pkg.sv
hdl/game_pkg.sv
hdl/game_control.sv
hdl/bird_physics.sv
hdl/obstacle_course.sv
hdl/sprite_draw.sv
hdl/screen_clear.sv
hdl/pixel_arbiter.sv
hdl/flap_game_top.sv
bench/flap_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the flap game core with its testbench and run the simulation
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module flap_tb \
	-f compile.f \
	-o flap_sim

# Exit status of the simulation decides pass or fail
./obj_dir/flap_sim
